// File: verilog/csr_pkg.sv
// csr_pkg
// shared types, CSR addresses and field constants for the machine-mode CSR unit

`default_nettype none

package csr_pkg;

  //////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  // bit 5 marks an interrupt, bits 4:0 hold the code
  typedef logic [5:0]  csr_cause_t;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // only user and machine levels exist
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  //////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////
  localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t ADDR_MIE       = 12'h304;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t ADDR_MEPC      = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t ADDR_MTVAL     = 12'h343;
  localparam csr_addr_t ADDR_MIP       = 12'h344;
  localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
  localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
  localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
  // performance counter block
  localparam csr_addr_t ADDR_PCER      = 12'h7A0;
  localparam csr_addr_t ADDR_PCMR      = 12'h7A1;
  localparam csr_addr_t ADDR_PCCR_BASE = 12'h780;
  localparam csr_addr_t ADDR_PCCR_ALL  = 12'h79F;

  //////////////////////////////////////////////////
  // fields and masks
  //////////////////////////////////////////////////
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  // mpp sits in bits 12:11
  localparam int MSTATUS_MPP_LO   = 11;
  localparam csr_data_t MSTATUS_RESET = 32'h0000_1800;
  // software, timer and external machine interrupts only
  localparam csr_data_t MIE_MASK      = 32'h0000_0888;
  localparam int IRQ_SFT_BIT = 3;
  localparam int IRQ_TMR_BIT = 7;
  localparam int IRQ_EXT_BIT = 11;

  // cycles, retired instr, loads, stores, taken branches
  localparam int N_PERF_EVENTS = 5;
  typedef logic [N_PERF_EVENTS-1:0] perf_evt_t;

endpackage

`default_nettype wire

// File: verilog/csr_bus_if.sv
// csr_bus_if
// resolved CSR access from the front end to both register banks,
// read data and hit flags back

`timescale 1ns/100ps
`default_nettype none

interface csr_bus_if
  import csr_pkg::*;
();

  // access side, wdata already resolved
  csr_addr_t addr;
  csr_data_t wdata;
  logic      we;
  // machine register bank answer
  csr_data_t m_rdata;
  logic      m_hit;
  // performance counter bank answer
  csr_data_t p_rdata;
  logic      p_hit;

  modport access (output addr, wdata, we, input m_rdata, m_hit, p_rdata, p_hit);
  modport mregs  (input addr, wdata, we, output m_rdata, m_hit);
  modport perf   (input addr, wdata, we, output p_rdata, p_hit);

endinterface

`default_nettype wire

// File: verilog/csr_access_unit.sv
// csr_access_unit
// front end of the CSR unit: read-data select, write/set/clear resolution
// and detection of accesses that no bank answers

`timescale 1ns/100ps
`default_nettype none

module csr_access_unit
  import csr_pkg::*;
(
  input  wire logic       csr_access_i,
  input  wire csr_op_e    csr_op_i,
  input  wire csr_addr_t  csr_addr_i,
  input  wire csr_data_t  csr_wdata_i,
  output csr_data_t       csr_rdata_o,
  output logic            csr_illegal_o,
  csr_bus_if.access       bus
);

  csr_data_t rdata_sel;
  csr_data_t wdata_res;

  // banks decode the address themselves
  assign bus.addr = csr_addr_i;

  // read data from whichever bank hits, zero otherwise
  always_comb begin
    if (bus.m_hit) begin
      rdata_sel = bus.m_rdata;
    end else if (bus.p_hit) begin
      rdata_sel = bus.p_rdata;
    end else begin
      rdata_sel = '0;
    end
  end

  assign csr_rdata_o = rdata_sel;

  //////////////////////////////////////////////////
  // operation resolution
  //////////////////////////////////////////////////
  always_comb begin
    unique case (csr_op_i)
      CSR_OP_SET:   wdata_res = csr_wdata_i | rdata_sel;
      CSR_OP_CLEAR: wdata_res = rdata_sel & ~csr_wdata_i;
      // write and none pass the raw value, none never strobes we
      default:      wdata_res = csr_wdata_i;
    endcase
  end

  assign bus.wdata = wdata_res;
  assign bus.we    = csr_access_i & (csr_op_i != CSR_OP_NONE);

  // nobody answered this address
  assign csr_illegal_o = csr_access_i & ~(bus.m_hit | bus.p_hit);

endmodule

`default_nettype wire

// File: verilog/csr_machine_regs.sv
// csr_machine_regs
// machine trap registers, trap entry and mret, privilege level and
// the 64-bit mcycle counter

`timescale 1ns/100ps
`default_nettype none

module csr_machine_regs
  import csr_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [3:0]  core_id_i,
  input  wire logic [5:0]  cluster_id_i,
  input  wire logic        ext_irq_i,
  input  wire logic        tmr_irq_i,
  input  wire logic        sft_irq_i,
  input  wire logic        trap_i,
  input  wire csr_cause_t  trap_cause_i,
  input  wire csr_data_t   trap_tval_i,
  input  wire csr_data_t   trap_pc_i,
  input  wire logic        mret_i,
  output csr_data_t        mtvec_o,
  output csr_data_t        epc_o,
  output priv_lvl_e        priv_lvl_o,
  output logic             m_irq_enable_o,
  output csr_data_t        mie_o,
  output csr_data_t        mip_o,
  csr_bus_if.mregs         bus
);

  // mstatus fields kept
  logic       mst_mie_q, mst_mie_d;
  logic       mst_mpie_q, mst_mpie_d;
  priv_lvl_e  mst_mpp_q, mst_mpp_d;
  priv_lvl_e  priv_q, priv_d;
  csr_data_t  mie_q, mie_d;
  csr_data_t  mtvec_q, mtvec_d;
  csr_data_t  mepc_q, mepc_d;
  csr_cause_t mcause_q, mcause_d;
  csr_data_t  mtval_q, mtval_d;
  csr_data_t  mip_q, mip_in;
  logic [63:0] mcycle_q, mcycle_d;
  csr_data_t  mstatus_rd;
  logic       wr_en;

  // pending irq levels in their mip positions
  always_comb begin
    mip_in              = '0;
    mip_in[IRQ_SFT_BIT] = sft_irq_i;
    mip_in[IRQ_TMR_BIT] = tmr_irq_i;
    mip_in[IRQ_EXT_BIT] = ext_irq_i;
  end

  always_comb begin
    mstatus_rd                         = '0;
    mstatus_rd[MSTATUS_MIE_BIT]        = mst_mie_q;
    mstatus_rd[MSTATUS_MPIE_BIT]       = mst_mpie_q;
    mstatus_rd[MSTATUS_MPP_LO +: 2]    = mst_mpp_q;
  end

  //////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////
  always_comb begin
    bus.m_hit   = 1'b1;
    bus.m_rdata = '0;
    case (bus.addr)
      ADDR_MSTATUS: bus.m_rdata = mstatus_rd;
      ADDR_MIE:     bus.m_rdata = mie_q;
      ADDR_MTVEC:   bus.m_rdata = mtvec_q;
      ADDR_MEPC:    bus.m_rdata = mepc_q;
      // packed form, irq flag on top
      ADDR_MCAUSE:  bus.m_rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};
      ADDR_MTVAL:   bus.m_rdata = mtval_q;
      ADDR_MIP:     bus.m_rdata = mip_q;
      ADDR_MHARTID: bus.m_rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      ADDR_MCYCLE:  bus.m_rdata = mcycle_q[31:0];
      ADDR_MCYCLEH: bus.m_rdata = mcycle_q[63:32];
      default:      bus.m_hit   = 1'b0;
    endcase
  end

  assign wr_en = bus.we & bus.m_hit;

  //////////////////////////////////////////////////
  // next state: csr write, then mret, then trap
  //////////////////////////////////////////////////
  always_comb begin
    mst_mie_d  = mst_mie_q;
    mst_mpie_d = mst_mpie_q;
    mst_mpp_d  = mst_mpp_q;
    priv_d     = priv_q;
    mie_d      = mie_q;
    mtvec_d    = mtvec_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    // free running unless a half is written
    mcycle_d   = mcycle_q + 64'd1;

    if (wr_en) begin
      case (bus.addr)
        ADDR_MSTATUS: begin
          mst_mie_d  = bus.wdata[MSTATUS_MIE_BIT];
          mst_mpie_d = bus.wdata[MSTATUS_MPIE_BIT];
          // only U or M legal for mpp
          mst_mpp_d  = (bus.wdata[MSTATUS_MPP_LO +: 2] == PRIV_LVL_M) ? PRIV_LVL_M : PRIV_LVL_U;
        end
        ADDR_MIE:     mie_d    = bus.wdata & MIE_MASK;
        ADDR_MTVEC:   mtvec_d  = {bus.wdata[31:2], 2'b00};
        ADDR_MEPC:    mepc_d   = bus.wdata;
        ADDR_MCAUSE:  mcause_d = {bus.wdata[31], bus.wdata[4:0]};
        ADDR_MTVAL:   mtval_d  = bus.wdata;
        ADDR_MCYCLE:  mcycle_d = {mcycle_q[63:32], bus.wdata};
        ADDR_MCYCLEH: mcycle_d = {bus.wdata, mcycle_q[31:0]};
        default: ;
      endcase
    end

    // return from trap
    if (mret_i) begin
      mst_mie_d  = mst_mpie_q;
      mst_mpie_d = 1'b1;
      priv_d     = mst_mpp_q;
      mst_mpp_d  = PRIV_LVL_U;
    end

    // trap entry, always into machine mode
    if (trap_i) begin
      mst_mpie_d = mst_mie_q;
      mst_mie_d  = 1'b0;
      mst_mpp_d  = priv_q;
      priv_d     = PRIV_LVL_M;
      mepc_d     = trap_pc_i;
      mcause_d   = trap_cause_i;
      mtval_d    = trap_tval_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mst_mie_q  <= MSTATUS_RESET[MSTATUS_MIE_BIT];
      mst_mpie_q <= MSTATUS_RESET[MSTATUS_MPIE_BIT];
      mst_mpp_q  <= priv_lvl_e'(MSTATUS_RESET[MSTATUS_MPP_LO +: 2]);
      priv_q     <= PRIV_LVL_M;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
      mcycle_q   <= '0;
    end else begin
      mst_mie_q  <= mst_mie_d;
      mst_mpie_q <= mst_mpie_d;
      mst_mpp_q  <= mst_mpp_d;
      priv_q     <= priv_d;
      mie_q      <= mie_d;
      mtvec_q    <= mtvec_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      // mip lags the irq pins by one cycle
      mip_q      <= mip_in;
      mcycle_q   <= mcycle_d;
    end
  end

  // status outputs
  assign mtvec_o        = mtvec_q;
  assign epc_o          = mepc_q;
  assign priv_lvl_o     = priv_q;
  assign m_irq_enable_o = mst_mie_q & (priv_q == PRIV_LVL_M);
  assign mie_o          = mie_q;
  assign mip_o          = mip_q;

endmodule

`default_nettype wire

// File: verilog/csr_perf_counters.sv
// csr_perf_counters
// event enable (PCER), mode (PCMR) and one counter per event,
// with optional saturation and a write-all alias

`timescale 1ns/100ps
`default_nettype none

module csr_perf_counters
  import csr_pkg::*;
#(
  parameter int PERF_CNT_WIDTH = 32
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  instr_retired_i,
  input  wire logic  mem_load_i,
  input  wire logic  mem_store_i,
  input  wire logic  branch_taken_i,
  csr_bus_if.perf    bus
);

  localparam logic [PERF_CNT_WIDTH-1:0] CNT_MAX = '1;

  perf_evt_t   pcer_q;
  // bit 0 global enable, bit 1 saturate
  logic [1:0]  pcmr_q;
  perf_evt_t   evt;
  perf_evt_t   inc_d, inc_q;
  logic [N_PERF_EVENTS-1:0][PERF_CNT_WIDTH-1:0] cnt_q, cnt_d;

  logic        sel_pcer, sel_pcmr, sel_all, sel_one;
  logic [4:0]  sel_idx;

  // event 0 counts every cycle
  assign evt = {branch_taken_i, mem_store_i, mem_load_i, instr_retired_i, 1'b1};

  // increment request, counted one edge later
  assign inc_d = evt & pcer_q & {N_PERF_EVENTS{pcmr_q[0]}};

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////
  assign sel_pcer = (bus.addr == ADDR_PCER);
  assign sel_pcmr = (bus.addr == ADDR_PCMR);
  assign sel_all  = (bus.addr == ADDR_PCCR_ALL);
  assign sel_idx  = bus.addr[4:0];
  // 0x780 window, only the implemented slots
  assign sel_one  = (bus.addr[11:5] == ADDR_PCCR_BASE[11:5]) && (sel_idx < N_PERF_EVENTS);

  assign bus.p_hit = sel_pcer | sel_pcmr | sel_all | sel_one;

  // read mux, counters zero-extended
  always_comb begin
    bus.p_rdata = '0;
    if (sel_pcer) begin
      bus.p_rdata = 32'(pcer_q);
    end else if (sel_pcmr) begin
      bus.p_rdata = 32'(pcmr_q);
    end else if (sel_one) begin
      for (int i = 0; i < N_PERF_EVENTS; i++) begin
        if (sel_idx == 5'(i)) begin
          bus.p_rdata = 32'(cnt_q[i]);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // counter update
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < N_PERF_EVENTS; i++) begin
      cnt_d[i] = cnt_q[i];
      // hold at all-ones when saturating
      if (inc_q[i] && ((cnt_q[i] != CNT_MAX) || !pcmr_q[1])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // csr write wins over the increment
      if (bus.we && (sel_all || (sel_one && sel_idx == 5'(i)))) begin
        cnt_d[i] = bus.wdata[PERF_CNT_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= 2'b11;
      inc_q  <= '0;
      cnt_q  <= '0;
    end else begin
      if (bus.we && sel_pcer) begin
        pcer_q <= bus.wdata[N_PERF_EVENTS-1:0];
      end
      if (bus.we && sel_pcmr) begin
        pcmr_q <= bus.wdata[1:0];
      end
      inc_q <= inc_d;
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/csr_unit.sv
// csr_unit
// machine-mode CSR unit top level: access front end feeding the
// machine register bank and the performance counter bank

`timescale 1ns/100ps
`default_nettype none

module csr_unit
  import csr_pkg::*;
#(
  parameter int PERF_CNT_WIDTH = 32
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  // csr access
  input  wire logic        csr_access_i,
  input  wire csr_addr_t   csr_addr_i,
  input  wire csr_op_e     csr_op_i,
  input  wire csr_data_t   csr_wdata_i,
  output csr_data_t        csr_rdata_o,
  output logic             csr_illegal_o,
  // hart identity
  input  wire logic [3:0]  core_id_i,
  input  wire logic [5:0]  cluster_id_i,
  // interrupt levels
  input  wire logic        ext_irq_i,
  input  wire logic        tmr_irq_i,
  input  wire logic        sft_irq_i,
  // trap and return
  input  wire logic        trap_i,
  input  wire csr_cause_t  trap_cause_i,
  input  wire csr_data_t   trap_tval_i,
  input  wire csr_data_t   trap_pc_i,
  input  wire logic        mret_i,
  // perf events
  input  wire logic        instr_retired_i,
  input  wire logic        mem_load_i,
  input  wire logic        mem_store_i,
  input  wire logic        branch_taken_i,
  // status
  output csr_data_t        mtvec_o,
  output csr_data_t        epc_o,
  output priv_lvl_e        priv_lvl_o,
  output logic             m_irq_enable_o,
  output csr_data_t        mie_o,
  output csr_data_t        mip_o
);

  csr_bus_if csr_bus ();

  csr_access_unit csr_access_unit_inst (
    .csr_access_i  (csr_access_i),
    .csr_op_i      (csr_op_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o),
    .bus           (csr_bus)
  );

  csr_machine_regs csr_machine_regs_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .ext_irq_i      (ext_irq_i),
    .tmr_irq_i      (tmr_irq_i),
    .sft_irq_i      (sft_irq_i),
    .trap_i         (trap_i),
    .trap_cause_i   (trap_cause_i),
    .trap_tval_i    (trap_tval_i),
    .trap_pc_i      (trap_pc_i),
    .mret_i         (mret_i),
    .mtvec_o        (mtvec_o),
    .epc_o          (epc_o),
    .priv_lvl_o     (priv_lvl_o),
    .m_irq_enable_o (m_irq_enable_o),
    .mie_o          (mie_o),
    .mip_o          (mip_o),
    .bus            (csr_bus)
  );

  csr_perf_counters #(
    .PERF_CNT_WIDTH (PERF_CNT_WIDTH)
  ) csr_perf_counters_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_retired_i (instr_retired_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .branch_taken_i  (branch_taken_i),
    .bus             (csr_bus)
  );

endmodule

`default_nettype wire

// File: tb/csr_unit_sva.sv
// csr_unit_sva
// concurrent checks on the CSR unit top-level ports

`timescale 1ns/100ps
`default_nettype none

module csr_unit_sva
  import csr_pkg::*;
(
  input wire logic      clk,
  input wire logic      rst_n,
  input wire logic      csr_access_i,
  input wire logic      csr_illegal_o,
  input wire logic      m_irq_enable_o,
  input wire priv_lvl_e priv_lvl_o,
  input wire csr_data_t mie_o
);

  // illegal only ever marks a real access
  illegal_needs_access: assert property (@(posedge clk) disable iff (!rst_n)
    csr_illegal_o |-> csr_access_i)
    else $error("illegal flag raised with no access");

  // machine irqs only enabled in M mode
  irq_enable_in_m: assert property (@(posedge clk) disable iff (!rst_n)
    m_irq_enable_o |-> (priv_lvl_o == PRIV_LVL_M))
    else $error("irq enable outside machine mode");

  mie_within_mask: assert property (@(posedge clk) disable iff (!rst_n)
    (mie_o & ~MIE_MASK) == '0)
    else $error("mie has bits outside the mask");

endmodule

bind csr_unit csr_unit_sva csr_unit_sva_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .csr_access_i   (csr_access_i),
  .csr_illegal_o  (csr_illegal_o),
  .m_irq_enable_o (m_irq_enable_o),
  .priv_lvl_o     (priv_lvl_o),
  .mie_o          (mie_o)
);

`default_nettype wire

// File: tb/tb_csr_unit.sv
// tb_csr_unit
// directed testbench for the machine-mode CSR unit

`timescale 1ns/100ps
`default_nettype none

module tb_csr_unit
  import csr_pkg::*;
();

  // about 300 cycles of tests, generous margin on top
  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  logic        csr_access_i;
  csr_addr_t   csr_addr_i;
  csr_op_e     csr_op_i;
  csr_data_t   csr_wdata_i;
  csr_data_t   csr_rdata_o;
  logic        csr_illegal_o;
  logic [3:0]  core_id_i;
  logic [5:0]  cluster_id_i;
  logic        ext_irq_i;
  logic        tmr_irq_i;
  logic        sft_irq_i;
  logic        trap_i;
  csr_cause_t  trap_cause_i;
  csr_data_t   trap_tval_i;
  csr_data_t   trap_pc_i;
  logic        mret_i;
  logic        instr_retired_i;
  logic        mem_load_i;
  logic        mem_store_i;
  logic        branch_taken_i;
  csr_data_t   mtvec_o;
  csr_data_t   epc_o;
  priv_lvl_e   priv_lvl_o;
  logic        m_irq_enable_o;
  csr_data_t   mie_o;
  csr_data_t   mip_o;

  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          err_base = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  // cycle stamp of the last sampled access
  int          access_cyc;
  logic [31:0] rng_state = 32'd25;
  int          tally [N_PERF_EVENTS];

  csr_unit csr_unit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic csr_data_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_data(input csr_data_t act, input csr_data_t exp_val, input string what);
    check_cnt++;
    if (act !== exp_val) begin
      err_cnt++;
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, act, exp_val);
    end
  endtask

  task automatic check_priv(input priv_lvl_e act, input priv_lvl_e exp_val, input string what);
    check_cnt++;
    if (act !== exp_val) begin
      err_cnt++;
      $display("mismatch at %0t: %s, got %0d expected %0d", $time, what, act, exp_val);
    end
  endtask

  task automatic check_flag(input logic act, input logic exp_val, input string what);
    check_cnt++;
    if (act !== exp_val) begin
      err_cnt++;
      $display("mismatch at %0t: %s, got %b expected %b", $time, what, act, exp_val);
    end
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - err_base);
    end
    err_base = err_cnt;
  endtask

  // one access cycle, sampled mid-cycle, then back to idle
  task automatic do_access(input csr_op_e op, input csr_addr_t addr, input csr_data_t wdata,
                           output csr_data_t rdata, output logic illegal);
    @(posedge clk);
    csr_access_i <= 1'b1;
    csr_op_i     <= op;
    csr_addr_i   <= addr;
    csr_wdata_i  <= wdata;
    @(negedge clk);
    rdata      = csr_rdata_o;
    illegal    = csr_illegal_o;
    access_cyc = cycle_cnt;
    @(posedge clk);
    csr_access_i <= 1'b0;
    csr_op_i     <= CSR_OP_NONE;
  endtask

  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    csr_data_t rd;
    logic      ill;
    do_access(CSR_OP_WRITE, addr, data, rd, ill);
  endtask

  task automatic csr_set(input csr_addr_t addr, input csr_data_t data);
    csr_data_t rd;
    logic      ill;
    do_access(CSR_OP_SET, addr, data, rd, ill);
  endtask

  task automatic csr_clear(input csr_addr_t addr, input csr_data_t data);
    csr_data_t rd;
    logic      ill;
    do_access(CSR_OP_CLEAR, addr, data, rd, ill);
  endtask

  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    logic ill;
    do_access(CSR_OP_NONE, addr, 32'd0, data, ill);
  endtask

  // returns mid-cycle after the registering edge
  task automatic pulse_trap(input csr_cause_t cause, input csr_data_t tval, input csr_data_t pc);
    @(posedge clk);
    trap_i       <= 1'b1;
    trap_cause_i <= cause;
    trap_tval_i  <= tval;
    trap_pc_i    <= pc;
    @(posedge clk);
    trap_i <= 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_mret();
    @(posedge clk);
    mret_i <= 1'b1;
    @(posedge clk);
    mret_i <= 1'b0;
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    csr_data_t v;
    csr_read(ADDR_MSTATUS, v);
    check_data(v, 32'h0000_1800, "mstatus reset");
    csr_read(ADDR_PCMR, v);
    check_data(v, 32'd3, "pcmr reset");
    csr_read(ADDR_PCER, v);
    check_data(v, 32'd0, "pcer reset");
    csr_read(ADDR_MTVEC, v);
    check_data(v, 32'd0, "mtvec reset");
    @(negedge clk);
    check_priv(priv_lvl_o, PRIV_LVL_M, "priv after reset");
    check_flag(m_irq_enable_o, 1'b0, "irq enable after reset");
    check_flag(csr_illegal_o, 1'b0, "illegal flag while idle");
    report_test("reset values");
  endtask

  task automatic test_access_ops();
    csr_data_t  r;
    csr_data_t  s;
    csr_data_t  c;
    csr_data_t  v;
    logic [3:0] core;
    logic [5:0] cluster;
    r = next_rand();
    s = next_rand();
    c = next_rand();
    csr_write(ADDR_MEPC, r);
    csr_read(ADDR_MEPC, v);
    check_data(v, r, "mepc write");
    csr_set(ADDR_MEPC, s);
    csr_read(ADDR_MEPC, v);
    check_data(v, r | s, "mepc set");
    csr_clear(ADDR_MEPC, c);
    csr_read(ADDR_MEPC, v);
    check_data(v, (r | s) & ~c, "mepc clear");
    @(negedge clk);
    check_data(epc_o, (r | s) & ~c, "epc_o");
    r = next_rand();
    csr_write(ADDR_MTVAL, r);
    csr_read(ADDR_MTVAL, v);
    check_data(v, r, "mtval write");
    // only msie, mtie, meie survive
    csr_write(ADDR_MIE, 32'hFFFF_FFFF);
    csr_read(ADDR_MIE, v);
    check_data(v, 32'h0000_0888, "mie mask");
    @(negedge clk);
    check_data(mie_o, 32'h0000_0888, "mie_o");
    r = next_rand();
    // low two bits forced high so the drop shows
    csr_write(ADDR_MTVEC, r | 32'h3);
    csr_read(ADDR_MTVEC, v);
    check_data(v, r & ~32'h3, "mtvec low bits");
    @(negedge clk);
    check_data(mtvec_o, r & ~32'h3, "mtvec_o");
    r = next_rand();
    core = r[3:0];
    cluster = r[9:4];
    @(posedge clk);
    core_id_i    <= core;
    cluster_id_i <= cluster;
    csr_read(ADDR_MHARTID, v);
    check_data(v, (32'(cluster) << 5) | 32'(core), "mhartid");
    // mip lags the irq pins by one edge
    @(posedge clk);
    ext_irq_i <= 1'b1;
    tmr_irq_i <= 1'b0;
    sft_irq_i <= 1'b1;
    @(negedge clk);
    check_data(mip_o, 32'd0, "mip before edge");
    @(negedge clk);
    check_data(mip_o, 32'h0000_0808, "mip after edge");
    csr_read(ADDR_MIP, v);
    check_data(v, 32'h0000_0808, "mip read");
    // timer line alone
    ext_irq_i <= 1'b0;
    tmr_irq_i <= 1'b1;
    sft_irq_i <= 1'b0;
    @(negedge clk);
    check_data(mip_o, 32'h0000_0808, "mip before timer edge");
    @(negedge clk);
    check_data(mip_o, 32'h0000_0080, "mip timer bit");
    @(posedge clk);
    tmr_irq_i <= 1'b0;
    report_test("write set clear");
  endtask

  task automatic test_trap_mret();
    csr_data_t v;
    csr_data_t pc;
    csr_data_t tval;
    pc = next_rand();
    tval = next_rand();
    csr_set(ADDR_MSTATUS, 32'h8);
    @(negedge clk);
    check_flag(m_irq_enable_o, 1'b1, "irq enable before trap");
    // external interrupt, code 11
    pulse_trap(6'h2B, tval, pc);
    check_priv(priv_lvl_o, PRIV_LVL_M, "priv after trap");
    check_flag(m_irq_enable_o, 1'b0, "irq enable after trap");
    check_data(epc_o, pc, "epc_o after trap");
    csr_read(ADDR_MSTATUS, v);
    check_data(v, 32'h0000_1880, "mstatus after trap");
    csr_read(ADDR_MEPC, v);
    check_data(v, pc, "mepc after trap");
    csr_read(ADDR_MCAUSE, v);
    check_data(v, 32'h8000_000B, "mcause packed");
    csr_read(ADDR_MTVAL, v);
    check_data(v, tval, "mtval after trap");
    pulse_mret();
    check_priv(priv_lvl_o, PRIV_LVL_M, "priv after mret");
    check_flag(m_irq_enable_o, 1'b1, "irq enable after mret");
    csr_read(ADDR_MSTATUS, v);
    check_data(v, 32'h0000_0088, "mstatus after mret");
    // mpp is U now
    pulse_mret();
    check_priv(priv_lvl_o, PRIV_LVL_U, "priv after mret to U");
    check_flag(m_irq_enable_o, 1'b0, "irq enable in U");
    pulse_trap(6'h02, tval, pc);
    check_priv(priv_lvl_o, PRIV_LVL_M, "priv after trap from U");
    csr_read(ADDR_MSTATUS, v);
    check_data(v, 32'h0000_0080, "mstatus after trap from U");
    csr_read(ADDR_MCAUSE, v);
    check_data(v, 32'h0000_0002, "mcause exception");
    report_test("trap and mret");
  endtask

  task automatic test_perf_counters();
    csr_data_t v;
    csr_data_t r;
    perf_evt_t en;
    logic      ill;
    int        k;
    // instr, loads, branches; cycles and stores stay off
    en = 5'b10110;
    for (k = 0; k < N_PERF_EVENTS; k++) begin
      tally[k] = 0;
    end
    csr_write(ADDR_PCER, 32'(en));
    csr_write(ADDR_PCCR_ALL, 32'd0);
    repeat (40) begin
      @(posedge clk);
      r = next_rand();
      instr_retired_i <= r[0];
      mem_load_i      <= r[1];
      mem_store_i     <= r[2];
      branch_taken_i  <= r[3];
      tally[1] = tally[1] + int'(r[0]);
      tally[2] = tally[2] + int'(r[1]);
      tally[3] = tally[3] + int'(r[2]);
      tally[4] = tally[4] + int'(r[3]);
    end
    @(posedge clk);
    instr_retired_i <= 1'b0;
    mem_load_i      <= 1'b0;
    mem_store_i     <= 1'b0;
    branch_taken_i  <= 1'b0;
    for (k = 0; k < N_PERF_EVENTS; k++) begin
      csr_read(ADDR_PCCR_BASE + csr_addr_t'(k), v);
      check_data(v, en[k] ? csr_data_t'(tally[k]) : 32'd0, "event counter");
    end
    // saturate on, cycle event counting
    csr_write(ADDR_PCER, 32'h1);
    csr_write(ADDR_PCCR_BASE, 32'hFFFF_FFFF);
    repeat (3) @(posedge clk);
    csr_read(ADDR_PCCR_BASE, v);
    check_data(v, 32'hFFFF_FFFF, "counter saturated");
    csr_write(ADDR_PCMR, 32'h1);
    csr_read(ADDR_PCCR_BASE, v);
    check_flag(v < 32'd4, 1'b1, "counter wraps without saturate");
    csr_write(ADDR_PCER, 32'd0);
    csr_write(ADDR_PCCR_ALL, 32'd0);
    for (k = 0; k < N_PERF_EVENTS; k++) begin
      csr_read(ADDR_PCCR_BASE + csr_addr_t'(k), v);
      check_data(v, 32'd0, "counter after clear all");
    end
    do_access(CSR_OP_NONE, ADDR_PCCR_ALL, 32'd0, v, ill);
    check_data(v, 32'd0, "pccr all read");
    check_flag(ill, 1'b0, "pccr all is legal");
    report_test("perf counters");
  endtask

  task automatic test_mcycle();
    csr_data_t a;
    csr_data_t b;
    csr_data_t hi;
    csr_data_t start;
    csr_data_t v;
    int        ca;
    int        cw;
    csr_read(ADDR_MCYCLE, a);
    ca = access_cyc;
    repeat (7) @(posedge clk);
    csr_read(ADDR_MCYCLE, b);
    check_data(b - a, csr_data_t'(access_cyc - ca), "mcycle delta");
    hi = next_rand();
    start = 32'hFFFF_FF00;
    csr_write(ADDR_MCYCLEH, hi);
    csr_write(ADDR_MCYCLE, start);
    cw = access_cyc;
    // value lands on the edge after the write cycle
    csr_read(ADDR_MCYCLE, v);
    check_data(v, start + csr_data_t'(access_cyc - cw - 1), "mcycle after write");
    repeat (5) @(posedge clk);
    csr_read(ADDR_MCYCLE, v);
    check_data(v, start + csr_data_t'(access_cyc - cw - 1), "mcycle keeps counting");
    csr_read(ADDR_MCYCLEH, v);
    check_data(v, hi, "mcycleh");
    report_test("mcycle");
  endtask

  task automatic test_illegal();
    csr_data_t v;
    csr_data_t epc_old;
    csr_data_t tval_old;
    csr_data_t tvec_old;
    logic      ill;
    csr_read(ADDR_MEPC, epc_old);
    csr_read(ADDR_MTVAL, tval_old);
    csr_read(ADDR_MTVEC, tvec_old);
    do_access(CSR_OP_WRITE, 12'h123, next_rand(), v, ill);
    check_flag(ill, 1'b1, "unmapped write flagged");
    check_data(v, 32'd0, "unmapped read data");
    // slot past the last counter
    do_access(CSR_OP_SET, ADDR_PCCR_BASE + 12'd5, 32'hFFFF_FFFF, v, ill);
    check_flag(ill, 1'b1, "missing counter flagged");
    check_data(v, 32'd0, "missing counter read data");
    do_access(CSR_OP_NONE, ADDR_MEPC, 32'd0, v, ill);
    check_flag(ill, 1'b0, "mapped access not flagged");
    check_data(v, epc_old, "mepc untouched");
    csr_read(ADDR_MTVAL, v);
    check_data(v, tval_old, "mtval untouched");
    csr_read(ADDR_MTVEC, v);
    check_data(v, tvec_old, "mtvec untouched");
    report_test("illegal access");
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    rst_n           <= 1'b0;
    csr_access_i    <= 1'b0;
    csr_addr_i      <= '0;
    csr_op_i        <= CSR_OP_NONE;
    csr_wdata_i     <= '0;
    core_id_i       <= 4'h5;
    cluster_id_i    <= 6'h2A;
    ext_irq_i       <= 1'b0;
    tmr_irq_i       <= 1'b0;
    sft_irq_i       <= 1'b0;
    trap_i          <= 1'b0;
    trap_cause_i    <= '0;
    trap_tval_i     <= '0;
    trap_pc_i       <= '0;
    mret_i          <= 1'b0;
    instr_retired_i <= 1'b0;
    mem_load_i      <= 1'b0;
    mem_store_i     <= 1'b0;
    branch_taken_i  <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_access_ops();
    test_trap_mret();
    test_perf_counters();
    test_mcycle();
    test_illegal();
    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: csr_unit.f
verilog/csr_pkg.sv
verilog/csr_bus_if.sv
verilog/csr_access_unit.sv
verilog/csr_machine_regs.sv
verilog/csr_perf_counters.sv
verilog/csr_unit.sv
tb/csr_unit_sva.sv
tb/tb_csr_unit.sv

// File: Makefile
SIM      := verilator
VFLAGS   := --binary --assert -Wno-fatal
TOP      := tb_csr_unit
FILELIST := csr_unit.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := Some tests failed
PASS_MSG := All tests passed
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
